// File: hdl/exu_pkg.sv
package exu_pkg;

    localparam int XLEN       = 64;
    localparam int REG_IDX_W  = 5;
    localparam int CSR_ADDR_W = 12;
    localparam int SHAMT_W    = $clog2(XLEN);

    localparam int INTAKE_DEPTH = 4;
    localparam int RESULT_DEPTH = 4;
    localparam int INTAKE_PTR_W = $clog2(INTAKE_DEPTH);
    localparam int INTAKE_CNT_W = $clog2(INTAKE_DEPTH + 1);
    localparam int RESULT_PTR_W = $clog2(RESULT_DEPTH);
    localparam int RESULT_CNT_W = $clog2(RESULT_DEPTH + 1);   // also sized for the credit count

    localparam int ALU_SRC_W = 3;
    localparam logic [ALU_SRC_W-1:0] ALU_SRC_REG     = 3'd0;
    localparam logic [ALU_SRC_W-1:0] ALU_SRC_IMM     = 3'd1;
    localparam logic [ALU_SRC_W-1:0] ALU_SRC_FOUR_PC = 3'd2;
    localparam logic [ALU_SRC_W-1:0] ALU_SRC_IMM_PC  = 3'd3;
    localparam logic [ALU_SRC_W-1:0] ALU_SRC_CSRRS   = 3'd4;
    localparam logic [ALU_SRC_W-1:0] ALU_SRC_ECALL   = 3'd5;
    localparam logic [ALU_SRC_W-1:0] ALU_SRC_ZERO    = 3'd6;

    localparam int ALU_OP_W = 4;
    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd9;
    localparam logic [ALU_OP_W-1:0] ALU_CSR  = 4'd10;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'd768;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC   = 12'd773;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'd833;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'd834;

    localparam logic [XLEN-1:0] CAUSE_ECALL = 64'd11;   // environment call from M mode

    // one instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [6:0]           funct7;
            logic [REG_IDX_W-1:0] rs2;
            logic [REG_IDX_W-1:0] rs1;
            logic [2:0]           funct3;
            logic [REG_IDX_W-1:0] rd;
            logic [6:0]           opcode;
        } r_fmt;
        struct packed {
            logic [11:0]          imm12;
            logic [REG_IDX_W-1:0] rs1;
            logic [2:0]           funct3;
            logic [REG_IDX_W-1:0] rd;
            logic [6:0]           opcode;
        } i_fmt;
        struct packed {
            logic [19:0]          imm20;
            logic [REG_IDX_W-1:0] rd;
            logic [6:0]           opcode;
        } u_fmt;
    } rv_instr_u;

endpackage

// File: hdl/instr_intake.sv
`timescale 1ns/100ps

module instr_intake import exu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            instr_valid,
    input  rv_instr_u       instr,
    input  logic [XLEN-1:0] instr_pc,
    input  logic            pop,
    output logic            head_valid,
    output rv_instr_u       head_instr,
    output logic [XLEN-1:0] head_pc,
    output logic            in_credit
);

    rv_instr_u               instr_mem [INTAKE_DEPTH];
    logic [XLEN-1:0]         pc_mem    [INTAKE_DEPTH];
    logic [INTAKE_PTR_W-1:0] wr_ptr;
    logic [INTAKE_PTR_W-1:0] rd_ptr;
    logic [INTAKE_CNT_W-1:0] count;

    assign head_valid = (count != '0);
    assign head_instr = instr_mem[rd_ptr];
    assign head_pc    = pc_mem[rd_ptr];

    // sender only pushes while it holds a credit, so no full check here
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            instr_mem[wr_ptr] <= instr;
            pc_mem[wr_ptr]    <= instr_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (instr_valid) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count     <= count + INTAKE_CNT_W'(instr_valid) - INTAKE_CNT_W'(pop);
            in_credit <= pop;   // one credit back per freed slot
        end
    end

endmodule

// File: hdl/instr_decode.sv
`timescale 1ns/100ps

module instr_decode import exu_pkg::*; (
    input  rv_instr_u             instr,
    output logic [ALU_SRC_W-1:0]  alu_src_sel,
    output logic [ALU_OP_W-1:0]   alu_op,
    output logic [REG_IDX_W-1:0]  rs1,
    output logic [REG_IDX_W-1:0]  rs2,
    output logic [REG_IDX_W-1:0]  rd,
    output logic [XLEN-1:0]       imm,
    output logic [CSR_ADDR_W-1:0] csr_addr,
    output logic                  rd_we,
    output logic                  csr_we,
    output logic                  ecall
);

    logic legal;   // encoding is one we execute

    assign rs1      = instr.r_fmt.rs1;
    assign rs2      = instr.r_fmt.rs2;
    assign csr_addr = instr.i_fmt.imm12;
    assign rd_we    = (rd != '0);   // rd forced to 0 for ecall and unknowns

    always_comb begin
        alu_src_sel = ALU_SRC_ZERO;
        alu_op      = ALU_ADD;
        imm         = '0;
        rd          = '0;
        legal       = 1'b0;
        csr_we      = 1'b0;
        ecall       = 1'b0;
        case (instr.r_fmt.opcode)
            OPC_OP: begin
                alu_src_sel = ALU_SRC_REG;
                rd          = instr.r_fmt.rd;
                legal       = (instr.r_fmt.funct7 == 7'h00);
                case (instr.r_fmt.funct3)
                    3'b000: begin
                        alu_op = ALU_ADD;
                        if (instr.r_fmt.funct7 == 7'h20) begin
                            alu_op = ALU_SUB;
                            legal  = 1'b1;
                        end
                    end
                    3'b001: alu_op = ALU_SLL;
                    3'b010: alu_op = ALU_SLT;
                    3'b011: alu_op = ALU_SLTU;
                    3'b100: alu_op = ALU_XOR;
                    3'b101: begin
                        alu_op = ALU_SRL;
                        if (instr.r_fmt.funct7 == 7'h20) begin
                            alu_op = ALU_SRA;
                            legal  = 1'b1;
                        end
                    end
                    3'b110: alu_op = ALU_OR;
                    default: alu_op = ALU_AND;
                endcase
            end
            OPC_OP_IMM: begin
                alu_src_sel = ALU_SRC_IMM;
                rd          = instr.i_fmt.rd;
                imm         = {{(XLEN-12){instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};
                legal       = 1'b1;
                case (instr.i_fmt.funct3)
                    3'b000: alu_op = ALU_ADD;
                    3'b010: alu_op = ALU_SLT;
                    3'b011: alu_op = ALU_SLTU;
                    3'b100: alu_op = ALU_XOR;
                    3'b110: alu_op = ALU_OR;
                    3'b111: alu_op = ALU_AND;
                    default: legal = 1'b0;   // immediate shifts not supported
                endcase
            end
            OPC_AUIPC: begin
                alu_src_sel = ALU_SRC_IMM_PC;
                rd          = instr.u_fmt.rd;
                imm         = {{(XLEN-32){instr.u_fmt.imm20[19]}}, instr.u_fmt.imm20, 12'h000};
                legal       = 1'b1;
            end
            OPC_JAL: begin
                alu_src_sel = ALU_SRC_FOUR_PC;   // link value only
                rd          = instr.u_fmt.rd;
                legal       = 1'b1;
            end
            OPC_SYSTEM: begin
                if (instr.i_fmt.funct3 == 3'b010) begin
                    alu_src_sel = ALU_SRC_CSRRS;
                    alu_op      = ALU_CSR;
                    rd          = instr.i_fmt.rd;
                    csr_we      = 1'b1;
                    legal       = 1'b1;
                end else if (instr.i_fmt.funct3 == 3'b000 && instr.i_fmt.imm12 == 12'h000) begin
                    alu_src_sel = ALU_SRC_ECALL;
                    alu_op      = ALU_OR;   // passes mtvec through
                    ecall       = 1'b1;
                    legal       = 1'b1;
                end
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            alu_src_sel = ALU_SRC_ZERO;
            alu_op      = ALU_ADD;
            rd          = '0;
        end
    end

endmodule

// File: hdl/regfile.sv
`timescale 1ns/100ps

module regfile import exu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [REG_IDX_W-1:0] rs1,
    input  logic [REG_IDX_W-1:0] rs2,
    output logic [XLEN-1:0]      rs1_data,
    output logic [XLEN-1:0]      rs2_data,
    input  logic [REG_IDX_W-1:0] rd,
    input  logic [XLEN-1:0]      rd_data,
    input  logic                 we
);

    logic [XLEN-1:0] regs [2**REG_IDX_W];

    // x0 reads as zero whatever is stored there
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_IDX_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[rd] <= rd_data;   // read back next cycle
        end
    end

endmodule

// File: hdl/mux_alu.sv
`timescale 1ns/100ps

module mux_alu import exu_pkg::*; (
    input  logic [ALU_SRC_W-1:0] alu_src_sel,
    input  logic [XLEN-1:0]      rs1_data,
    input  logic [XLEN-1:0]      rs2_data,
    input  logic [XLEN-1:0]      imm,
    input  logic [XLEN-1:0]      curr_pc,
    input  logic [XLEN-1:0]      csr_rdata,
    output logic [XLEN-1:0]      alu_src1,
    output logic [XLEN-1:0]      alu_src2
);

    always_comb begin
        alu_src1 = '0;
        alu_src2 = '0;
        case (alu_src_sel)
            ALU_SRC_REG: begin
                alu_src1 = rs1_data;
                alu_src2 = rs2_data;
            end
            ALU_SRC_IMM: begin
                alu_src1 = rs1_data;
                alu_src2 = imm;
            end
            ALU_SRC_FOUR_PC: begin
                alu_src1 = XLEN'(4);   // jal link
                alu_src2 = curr_pc;
            end
            ALU_SRC_IMM_PC: begin
                alu_src1 = imm;
                alu_src2 = curr_pc;
            end
            ALU_SRC_CSRRS: begin
                alu_src1 = rs1_data;   // bits to set
                alu_src2 = csr_rdata;  // old csr value
            end
            ALU_SRC_ECALL: begin
                alu_src1 = csr_rdata;  // mtvec on ecall
                alu_src2 = '0;
            end
            default: begin
                alu_src1 = '0;
                alu_src2 = '0;
            end
        endcase
    end

endmodule

// File: hdl/alu.sv
`timescale 1ns/100ps

module alu import exu_pkg::*; (
    input  logic [ALU_OP_W-1:0] alu_op,
    input  logic [XLEN-1:0]     alu_src1,
    input  logic [XLEN-1:0]     alu_src2,
    output logic [XLEN-1:0]     result,
    output logic [XLEN-1:0]     csr_wdata
);

    logic [SHAMT_W-1:0] shamt;

    assign shamt = alu_src2[SHAMT_W-1:0];   // low six bits only

    // csrrs sets bits, only written when the decoder asks for it
    assign csr_wdata = alu_src2 | alu_src1;

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = alu_src1 + alu_src2;
            ALU_SUB:  result = alu_src1 - alu_src2;
            ALU_AND:  result = alu_src1 & alu_src2;
            ALU_OR:   result = alu_src1 | alu_src2;
            ALU_XOR:  result = alu_src1 ^ alu_src2;
            ALU_SLL:  result = alu_src1 << shamt;
            ALU_SRL:  result = alu_src1 >> shamt;
            ALU_SRA:  result = $signed(alu_src1) >>> shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(alu_src1) < $signed(alu_src2)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, alu_src1 < alu_src2};
            ALU_CSR:  result = alu_src2;   // old csr value to rd
            default:  result = '0;
        endcase
    end

endmodule

// File: hdl/csr_file.sv
`timescale 1ns/100ps

module csr_file import exu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [CSR_ADDR_W-1:0] csr_addr,
    output logic [XLEN-1:0]       csr_rdata,
    input  logic                  csr_we,
    input  logic [XLEN-1:0]       csr_wdata,
    input  logic                  ecall,
    input  logic [XLEN-1:0]       ecall_pc,
    input  logic                  issue
);

    logic [XLEN-1:0]       mstatus;
    logic [XLEN-1:0]       mtvec;
    logic [XLEN-1:0]       mepc;
    logic [XLEN-1:0]       mcause;
    logic [CSR_ADDR_W-1:0] rd_addr;

    assign rd_addr = ecall ? CSR_MTVEC : csr_addr;   // trap target on ecall

    always_comb begin
        case (rd_addr)
            CSR_MSTATUS: csr_rdata = mstatus;
            CSR_MTVEC:   csr_rdata = mtvec;
            CSR_MEPC:    csr_rdata = mepc;
            CSR_MCAUSE:  csr_rdata = mcause;
            default:     csr_rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (issue) begin
            if (ecall) begin
                mepc   <= ecall_pc;
                mcause <= CAUSE_ECALL;
            end else if (csr_we) begin
                case (csr_addr)
                    CSR_MSTATUS: mstatus <= csr_wdata;
                    CSR_MTVEC:   mtvec   <= csr_wdata;
                    CSR_MEPC:    mepc    <= csr_wdata;
                    CSR_MCAUSE:  mcause  <= csr_wdata;
                    default:     ;   // unmapped, write dropped
                endcase
            end
        end
    end

endmodule

// File: hdl/result_queue.sv
`timescale 1ns/100ps

module result_queue import exu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 push,
    input  logic [REG_IDX_W-1:0] push_rd,
    input  logic [XLEN-1:0]      push_data,
    input  logic [XLEN-1:0]      push_pc,
    output logic                 space,
    input  logic                 out_credit,
    output logic                 res_valid,
    output logic [REG_IDX_W-1:0] res_rd,
    output logic [XLEN-1:0]      res_data,
    output logic [XLEN-1:0]      res_pc
);

    logic [REG_IDX_W-1:0]    rd_mem   [RESULT_DEPTH];
    logic [XLEN-1:0]         data_mem [RESULT_DEPTH];
    logic [XLEN-1:0]         pc_mem   [RESULT_DEPTH];
    logic [RESULT_PTR_W-1:0] wr_ptr;
    logic [RESULT_PTR_W-1:0] rd_ptr;
    logic [RESULT_CNT_W-1:0] count;
    logic [RESULT_CNT_W-1:0] credits;   // downstream slots we may fill

    assign space     = (count != RESULT_CNT_W'(RESULT_DEPTH));
    assign res_valid = (count != '0) && (credits != '0);   // a send every valid cycle
    assign res_rd    = rd_mem[rd_ptr];
    assign res_data  = data_mem[rd_ptr];
    assign res_pc    = pc_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            rd_mem[wr_ptr]   <= push_rd;
            data_mem[wr_ptr] <= push_data;
            pc_mem[wr_ptr]   <= push_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= RESULT_CNT_W'(RESULT_DEPTH);
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (res_valid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count   <= count + RESULT_CNT_W'(push) - RESULT_CNT_W'(res_valid);
            credits <= credits + RESULT_CNT_W'(out_credit) - RESULT_CNT_W'(res_valid);
        end
    end

endmodule

// File: hdl/exec_unit.sv
`timescale 1ns/100ps

module exec_unit import exu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 instr_valid,
    input  rv_instr_u            instr,
    input  logic [XLEN-1:0]      instr_pc,
    output logic                 in_credit,
    output logic                 res_valid,
    output logic [REG_IDX_W-1:0] res_rd,
    output logic [XLEN-1:0]      res_data,
    output logic [XLEN-1:0]      res_pc,
    input  logic                 out_credit
);

    logic                  head_valid;
    rv_instr_u             head_instr;
    logic [XLEN-1:0]       head_pc;
    logic                  issue;
    logic                  space;
    logic [ALU_SRC_W-1:0]  alu_src_sel;
    logic [ALU_OP_W-1:0]   alu_op;
    logic [REG_IDX_W-1:0]  rs1;
    logic [REG_IDX_W-1:0]  rs2;
    logic [REG_IDX_W-1:0]  rd;
    logic [XLEN-1:0]       imm;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic                  rd_we;
    logic                  csr_we;
    logic                  ecall;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       csr_rdata;
    logic [XLEN-1:0]       alu_src1;
    logic [XLEN-1:0]       alu_src2;
    logic [XLEN-1:0]       alu_result;
    logic [XLEN-1:0]       csr_wdata;

    assign issue = head_valid & space;   // one instruction per cycle at most

    instr_intake u_intake (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
        .instr_pc(instr_pc), .pop(issue), .head_valid(head_valid),
        .head_instr(head_instr), .head_pc(head_pc), .in_credit(in_credit)
    );

    instr_decode u_decode (
        .instr(head_instr), .alu_src_sel(alu_src_sel), .alu_op(alu_op),
        .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .csr_addr(csr_addr),
        .rd_we(rd_we), .csr_we(csr_we), .ecall(ecall)
    );

    regfile u_regfile (
        .clk(clk), .rst_n(rst_n), .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .rd(rd), .rd_data(alu_result), .we(issue & rd_we)
    );

    mux_alu u_mux_alu (
        .alu_src_sel(alu_src_sel), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .imm(imm), .curr_pc(head_pc), .csr_rdata(csr_rdata),
        .alu_src1(alu_src1), .alu_src2(alu_src2)
    );

    alu u_alu (
        .alu_op(alu_op), .alu_src1(alu_src1), .alu_src2(alu_src2),
        .result(alu_result), .csr_wdata(csr_wdata)
    );

    csr_file u_csr_file (
        .clk(clk), .rst_n(rst_n), .csr_addr(csr_addr), .csr_rdata(csr_rdata),
        .csr_we(csr_we), .csr_wdata(csr_wdata), .ecall(ecall),
        .ecall_pc(head_pc), .issue(issue)
    );

    result_queue u_result_queue (
        .clk(clk), .rst_n(rst_n), .push(issue), .push_rd(rd), .push_data(alu_result),
        .push_pc(head_pc), .space(space), .out_credit(out_credit),
        .res_valid(res_valid), .res_rd(res_rd), .res_data(res_data), .res_pc(res_pc)
    );

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk
);

    localparam real HALF_PERIOD = 4.0;   // 8 ns period

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

// File: testbench/exec_unit_tb.sv
`timescale 1ns/100ps

module exec_unit_tb import exu_pkg::*; ();

    localparam int NUM_INSTR      = 400;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 10 + 200;
    localparam int HOLD_AFTER     = 200;   // instructions sent before credits are withheld
    localparam int HOLD_CYCLES    = 50;
    localparam logic [XLEN-1:0] PC_BASE = 64'h0000_0000_8000_0000;
    localparam logic [2:0] R_F3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    localparam logic [2:0] I_F3 [6]  = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};

    logic                 clk;
    logic                 rst_n;
    logic                 instr_valid;
    rv_instr_u            instr;
    logic [XLEN-1:0]      instr_pc;
    logic                 in_credit;
    logic                 res_valid;
    logic [REG_IDX_W-1:0] res_rd;
    logic [XLEN-1:0]      res_data;
    logic [XLEN-1:0]      res_pc;
    logic                 out_credit;

    logic [XLEN-1:0]      model_rf  [32];
    logic [XLEN-1:0]      model_csr [4];   // mstatus, mtvec, mepc, mcause
    logic [XLEN-1:0]      exp_data  [$];
    logic [REG_IDX_W-1:0] exp_rd    [$];
    logic [XLEN-1:0]      exp_pc    [$];
    int                   exp_cat   [$];
    int                   credit_due [$];   // cycle when each consumed result's credit goes back

    string cat_name [4] = '{"alu_ops", "auipc_jal", "csrrs", "ecall_unknown"};
    int    cat_checks [4];
    int    cat_errors [4];
    int    flow_checks;
    int    flow_errors;
    int    errors;
    int    cycle;
    int    sent;
    int    results;
    int    up_credits;
    int    dn_credits;
    int    credit_returns;
    int    hold_start;
    int    hold_credits;
    int    hold_sends;
    logic  holding;
    logic [31:0]     word;
    logic [XLEN-1:0] next_pc;

    tb_clock u_clock (.clk(clk));

    exec_unit dut (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
        .instr_pc(instr_pc), .in_credit(in_credit), .res_valid(res_valid),
        .res_rd(res_rd), .res_data(res_data), .res_pc(res_pc), .out_credit(out_credit)
    );

    function automatic logic [11:0] csr_addr_of(input int idx);
        case (idx)
            0: return CSR_MSTATUS;
            1: return CSR_MTVEC;
            2: return CSR_MEPC;
            3: return CSR_MCAUSE;
            default: return 12'h7c0;   // not implemented
        endcase
    endfunction

    // random instruction, applied to the model as it is made
    task automatic build_instr(input logic [XLEN-1:0] pc, output logic [31:0] w);
        int                   pick;
        int                   k;
        int                   cat;
        logic [REG_IDX_W-1:0] rd;
        logic [REG_IDX_W-1:0] rs1;
        logic [REG_IDX_W-1:0] rs2;
        logic [11:0]          imm12;
        logic [19:0]          imm20;
        logic [6:0]           opc;
        logic [XLEN-1:0]      a;
        logic [XLEN-1:0]      b;
        logic [XLEN-1:0]      res;
        pick  = $urandom_range(0, 99);
        rd    = REG_IDX_W'($urandom_range(0, 23));   // x24 and up never written
        rs1   = REG_IDX_W'($urandom_range(0, 31));
        rs2   = REG_IDX_W'($urandom_range(0, 31));
        imm12 = 12'($urandom);
        imm20 = 20'($urandom);
        a     = model_rf[rs1];
        b     = model_rf[rs2];
        if (pick < 70) begin
            cat = 0;
            if (pick < 40) begin
                k = $urandom_range(0, 9);
                w = {(k == 1 || k == 7) ? 7'h20 : 7'h00, rs2, rs1, R_F3[k], rd, OPC_OP};
            end else begin
                k = $urandom_range(0, 5);
                b = {{(XLEN-12){imm12[11]}}, imm12};
                k = (k == 0) ? 0 : k + 2;   // addi slti sltiu xori ori andi
                w = {imm12, rs1, I_F3[(k == 0) ? 0 : k - 2], rd, OPC_OP_IMM};
                k = (k == 3) ? 3 : (k == 4) ? 4 : (k == 5) ? 5 : (k == 6) ? 8 : (k == 7) ? 9 : k;
            end
            case (k)
                0: res = a + b;
                1: res = a - b;
                2: res = a << b[SHAMT_W-1:0];
                3: res = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
                4: res = {{(XLEN-1){1'b0}}, a < b};
                5: res = a ^ b;
                6: res = a >> b[SHAMT_W-1:0];
                7: res = $signed(a) >>> b[SHAMT_W-1:0];
                8: res = a | b;
                default: res = a & b;
            endcase
        end else if (pick < 82) begin
            cat = 1;
            if (pick < 76) begin
                res = pc + {{(XLEN-32){imm20[19]}}, imm20, 12'h000};
                w   = {imm20, rd, OPC_AUIPC};
            end else begin
                res = pc + XLEN'(4);   // link value
                w   = {imm20, rd, OPC_JAL};
            end
        end else if (pick < 91) begin
            cat = 2;
            k   = $urandom_range(0, 4);
            res = (k < 4) ? model_csr[k] : '0;
            if (k < 4) begin
                model_csr[k] = model_csr[k] | a;
            end
            w = {csr_addr_of(k), rs1, 3'b010, rd, OPC_SYSTEM};
        end else begin
            cat = 3;
            rd  = '0;
            if (pick < 96) begin
                res          = model_csr[1];   // trap vector
                model_csr[2] = pc;
                model_csr[3] = CAUSE_ECALL;
                w            = 32'h0000_0073;
            end else begin
                case ($urandom_range(0, 2))
                    0: opc = 7'b0000011;
                    1: opc = 7'b0100011;
                    default: opc = 7'b1100011;
                endcase
                res = '0;
                w   = {25'($urandom), opc};
            end
        end
        if (rd != '0) begin
            model_rf[rd] = res;
        end
        exp_data.push_back(res);
        exp_rd.push_back(rd);
        exp_pc.push_back(pc);
        exp_cat.push_back(cat);
    endtask

    task automatic check_result(input logic [XLEN-1:0] data, input logic [REG_IDX_W-1:0] rd,
                                input logic [XLEN-1:0] pc);
        int cat;
        if (exp_data.size() == 0) begin
            $display("result seen at %0t with no instruction outstanding", $time);
            errors++;
            flow_errors++;
        end else begin
            cat = exp_cat.pop_front();
            cat_checks[cat]++;
            if (data !== exp_data[0] || rd !== exp_rd[0] || pc !== exp_pc[0]) begin
                $display("FAIL %0t: got rd %0d data %h pc %h, expected rd %0d data %h pc %h",
                         $time, rd, data, pc, exp_rd[0], exp_data[0], exp_pc[0]);
                errors++;
                cat_errors[cat]++;
            end
            void'(exp_data.pop_front());
            void'(exp_rd.pop_front());
            void'(exp_pc.pop_front());
        end
    endtask

    task automatic check_credits(input string what, input int count, input int lo, input int hi);
        flow_checks++;
        if (count < lo || count > hi) begin
            $display("FAIL %0t: %s is %0d, allowed %0d to %0d", $time, what, count, lo, hi);
            errors++;
            flow_errors++;
        end
    endtask

    initial begin
        void'($urandom(37944));
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        instr_pc    = '0;
        out_credit  = 1'b0;
        foreach (model_rf[i]) model_rf[i] = '0;
        foreach (model_csr[i]) model_csr[i] = '0;
        up_credits = INTAKE_DEPTH;
        dn_credits = RESULT_DEPTH;
        hold_start = -1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        while (results < NUM_INSTR && cycle < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycle++;
            holding = (hold_start >= 0) && (cycle >= hold_start) &&
                      (cycle < hold_start + HOLD_CYCLES);
            if (in_credit) begin
                up_credits++;
                credit_returns++;
            end
            check_credits("upstream credits held by sender", up_credits, 0, INTAKE_DEPTH);
            if (res_valid) begin   // send happens at the next rising edge
                check_credits("downstream credits at a send", dn_credits, 1, RESULT_DEPTH);
                dn_credits--;
                if (holding) begin
                    hold_sends++;
                end
                check_result(res_data, res_rd, res_pc);
                results++;
                credit_due.push_back(cycle + int'($urandom_range(0, 5)));
            end
            if (hold_start >= 0 && cycle == hold_start + HOLD_CYCLES) begin
                check_credits("results sent while credits withheld", hold_sends, 0, hold_credits);
            end
            out_credit = 1'b0;
            if (!holding && credit_due.size() > 0 && credit_due[0] <= cycle) begin
                void'(credit_due.pop_front());
                out_credit = 1'b1;
                dn_credits++;
            end
            instr_valid = 1'b0;
            if (sent < NUM_INSTR && up_credits > 0 && $urandom_range(0, 3) != 0) begin
                next_pc = PC_BASE + XLEN'(4 * sent);
                build_instr(next_pc, word);
                instr       = word;
                instr_pc    = next_pc;
                instr_valid = 1'b1;
                up_credits--;
                sent++;
                if (sent == HOLD_AFTER) begin
                    hold_start   = cycle + 1;
                    hold_credits = dn_credits;
                end
            end
        end
        if (results < NUM_INSTR) begin
            $display("timeout after %0d cycles with %0d of %0d results received",
                     cycle, results, NUM_INSTR);
        end
        check_credits("in_credit pulses", credit_returns, NUM_INSTR, NUM_INSTR);
        if (hold_start < 0) begin
            $display("credit hold never started");
            errors++;
            flow_errors++;
        end
        foreach (cat_name[i]) begin
            $display("test %-14s %0d checks, %0d errors", cat_name[i], cat_checks[i], cat_errors[i]);
        end
        $display("test %-14s %0d checks, %0d errors", "flow_control", flow_checks, flow_errors);
        $display("summary: %0d results, %0d cycles, %0d errors", results, cycle, errors);
        if (errors == 0 && results == NUM_INSTR) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: exec_unit.f
hdl/exu_pkg.sv
hdl/instr_intake.sv
hdl/instr_decode.sv
hdl/regfile.sv
hdl/mux_alu.sv
hdl/alu.sv
hdl/csr_file.sv
hdl/result_queue.sv
hdl/exec_unit.sv
testbench/tb_clock.sv
testbench/exec_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the exec_unit testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
    --top-module exec_unit_tb -f exec_unit.f -o exec_unit_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/exec_unit_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TEST OK" "$LOG"; then
    echo "no pass line found in $LOG"
    exit 1
fi
exit 0
